// File: hw/erx_defines.svh
`ifndef ERX_DEFINES_SVH
`define ERX_DEFINES_SVH

// heartbeat counter width, one beat every 2**RCW cycles
`define ERX_RCW 4

// packet fifo geometry
`define ERX_FIFO_DEPTH 4
`define ERX_FIFO_PW 2   // pointer bits, depth is a power of two
`define ERX_FIFO_CW 3   // count bits, holds 0..depth

// bus widths
`define ERX_AW 32
`define ERX_DW 32

// ctrl byte + 4 address bytes + 4 payload bytes, msb first
`define ERX_FRAME_BYTES 9

`endif

// File: hw/erx_pkg.sv
`default_nettype none

`include "erx_defines.svh"

package erx_pkg;

   // one payload word, meaning depends on the write flag
   typedef union packed {
      logic [`ERX_DW-1:0] wr_data;  // write packet: data to store
      logic [`ERX_AW-1:0] src_addr; // read packet: where the answer goes
   } erx_payload_t;

   // 65 bits, write flag on top
   typedef struct packed {
      logic               write;    // bit 0 of the ctrl byte
      logic [`ERX_AW-1:0] dst_addr;
      erx_payload_t       payload;
   } erx_packet_t;

   // reset sequencer states
   typedef enum logic [1:0] {
      reset_all = 2'b00,  // pll held in reset
      start_pll = 2'b01,  // waiting for lock and idelay ready
      active    = 2'b10   // link up
   } erx_rst_state_t;

endpackage

`default_nettype wire

// File: hw/erx_wb_if.sv
`default_nettype none

// wishbone classic, one packet per cycle
interface erx_wb_if;
   import erx_pkg::*;

   logic        cyc;
   logic        stb;
   logic        we;   // high: master writes dat, low: slave returns dat
   wire  erx_packet_t dat; // net, driven by whichever side owns the transfer
   logic        ack;  // registered in the slave

   modport master (
      output cyc,
      output stb,
      output we,
      inout  dat,
      input  ack
   );

   modport slave (
      input  cyc,
      input  stb,
      input  we,
      inout  dat,
      output ack
   );

endinterface

`default_nettype wire

// File: hw/erx_reset_ctrl.sv
`default_nettype none

`include "erx_defines.svh"

module erx_reset_ctrl (
   input  logic sys_clk,
   input  logic rx_reset,      // por
   input  logic soft_reset,    // sw receive disable
   input  logic tx_active,     // far end alive
   input  logic pll_locked,    // async, from pll
   input  logic idelay_ready,  // from delay controller
   output logic pll_reset,
   output logic rx_active,
   output logic core_reset     // async assert, sync release
);
   import erx_pkg::*;

   logic [`ERX_RCW-1:0] hb_cnt;     // free running
   logic                heartbeat;  // one cycle per wrap
   logic                lock_meta;
   logic                lock_sync;
   logic                seq_reset;
   logic                core_hold;
   logic [1:0]          core_pipe;
   erx_rst_state_t      state;

   //##############################
   // heartbeat
   //##############################
   always_ff @(posedge sys_clk or posedge rx_reset)
   begin
      if (rx_reset)
      begin
         hb_cnt    <= '0;
         heartbeat <= 1'b0;
      end
      else
      begin
         hb_cnt    <= hb_cnt + 1'b1;
         heartbeat <= ~(|hb_cnt);  // fires once counter wraps to zero
      end
   end

   // pll lock into sys_clk domain, two flops
   always_ff @(posedge sys_clk or posedge rx_reset)
   begin
      if (rx_reset)
      begin
         lock_meta <= 1'b0;
         lock_sync <= 1'b0;
      end
      else
      begin
         lock_meta <= pll_locked;
         lock_sync <= lock_meta;
      end
   end

   //##############################
   // sequencer
   //##############################
   assign seq_reset = rx_reset | ~tx_active;  // quiet while tx is down

   always_ff @(posedge sys_clk or posedge seq_reset)
   begin
      if (seq_reset)
         state <= reset_all;
      else if (heartbeat)  // only steps on the beat
      begin
         case (state)
            reset_all:
               if (!soft_reset)
                  state <= start_pll;
            start_pll:
               if (lock_sync && idelay_ready)
                  state <= active;
            active:
               if (soft_reset)
                  state <= reset_all;  // parks until soft_reset drops
            default:
               state <= reset_all;
         endcase
      end
   end

   assign pll_reset = (state == reset_all);
   assign rx_active = (state == active);
   assign core_hold = (state != active);

   //##############################
   // core reset release
   //##############################
   // asserted with the state change, released two edges after rx_active
   always_ff @(posedge sys_clk or posedge core_hold)
   begin
      if (core_hold)
         core_pipe <= 2'b00;
      else
         core_pipe <= {core_pipe[0], 1'b1};
   end

   assign core_reset = ~core_pipe[1];

endmodule

`default_nettype wire

// File: hw/erx_protocol.sv
`default_nettype none

`include "erx_defines.svh"

module erx_protocol (
   input  logic       sys_clk,
   input  logic       core_reset,
   input  logic       rx_frame,   // high for every byte of a frame
   input  logic [7:0] rx_data,
   erx_wb_if.master   wr          // into fifo write port
);
   import erx_pkg::*;

   logic [3:0]                        byte_cnt;   // bytes taken so far
   logic [8*(`ERX_FRAME_BYTES-1)-1:0] frame_sr;   // first eight bytes
   logic [8*`ERX_FRAME_BYTES-1:0]     frame_word; // whole frame incl. last byte
   logic                              last_byte;
   logic                              hold_valid; // packet on offer
   erx_packet_t                       hold_pkt;

   assign last_byte  = rx_frame & (byte_cnt == 4'(`ERX_FRAME_BYTES - 1));
   assign frame_word = {frame_sr, rx_data};

   //##############################
   // byte assembly
   //##############################
   always_ff @(posedge sys_clk or posedge core_reset)
   begin
      if (core_reset)
         byte_cnt <= '0;
      else if (!rx_frame)
         byte_cnt <= '0;  // idle, or frame cut short
      else if (last_byte)
         byte_cnt <= '0;
      else
         byte_cnt <= byte_cnt + 1'b1;
   end

   // msb first, so shift left
   always_ff @(posedge sys_clk)
   begin
      if (rx_frame)
         frame_sr <= {frame_sr[8*(`ERX_FRAME_BYTES-2)-1:0], rx_data};
   end

   //##############################
   // holding register
   //##############################
   // frame finishing while the previous packet still waits is dropped
   always_ff @(posedge sys_clk or posedge core_reset)
   begin
      if (core_reset)
         hold_valid <= 1'b0;
      else if (hold_valid)
      begin
         if (wr.ack)
            hold_valid <= 1'b0;  // stb low the cycle after ack
      end
      else if (last_byte)
         hold_valid <= 1'b1;
   end

   always_ff @(posedge sys_clk)
   begin
      if (last_byte && !hold_valid)
      begin
         hold_pkt.write    <= frame_word[8*(`ERX_FRAME_BYTES-1)]; // ctrl bit 0
         hold_pkt.dst_addr <= frame_word[`ERX_AW+`ERX_DW-1:`ERX_DW];
         hold_pkt.payload  <= frame_word[`ERX_DW-1:0];
      end
   end

   assign wr.cyc = hold_valid;
   assign wr.stb = hold_valid;
   assign wr.we  = 1'b1;      // always pushing
   assign wr.dat = hold_pkt;  // steady while stb

endmodule

`default_nettype wire

// File: hw/erx_fifo.sv
`default_nettype none

`include "erx_defines.svh"

module erx_fifo (
   input  logic     sys_clk,
   input  logic     core_reset,
   erx_wb_if.slave  wr,       // from assembler
   erx_wb_if.slave  rd,       // from dispatcher
   output logic     rx_wait   // tell sender to pause
);
   import erx_pkg::*;

   erx_packet_t             mem [0:`ERX_FIFO_DEPTH-1];
   logic [`ERX_FIFO_PW-1:0] wr_ptr;
   logic [`ERX_FIFO_PW-1:0] rd_ptr;
   logic [`ERX_FIFO_CW-1:0] count;
   logic [`ERX_FIFO_CW-1:0] free_cnt;
   logic                    full;
   logic                    empty;
   logic                    wr_go;     // accept a write this cycle
   logic                    rd_go;     // accept a read this cycle
   logic                    wr_ack_q;
   logic                    rd_ack_q;
   erx_packet_t             rd_dat_q;

   assign free_cnt = `ERX_FIFO_CW'(`ERX_FIFO_DEPTH) - count;
   assign full     = (free_cnt == '0);
   assign empty    = (count == '0);
   assign rx_wait  = (free_cnt < `ERX_FIFO_CW'(2));  // room for under two

   // ack guard keeps one accept per cycle
   assign wr_go = wr.cyc & wr.stb & wr.we & ~wr_ack_q & ~full;
   assign rd_go = rd.cyc & rd.stb & ~rd.we & ~rd_ack_q & ~empty;

   //##############################
   // pointers and count
   //##############################
   always_ff @(posedge sys_clk or posedge core_reset)
   begin
      if (core_reset)
      begin
         wr_ptr   <= '0;
         rd_ptr   <= '0;
         count    <= '0;
         wr_ack_q <= 1'b0;
         rd_ack_q <= 1'b0;
      end
      else
      begin
         wr_ack_q <= wr_go;
         rd_ack_q <= rd_go;
         if (wr_go)
            wr_ptr <= wr_ptr + 1'b1;  // wraps, depth is 2**pw
         if (rd_go)
            rd_ptr <= rd_ptr + 1'b1;
         case ({wr_go, rd_go})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;  // none or both
         endcase
      end
   end

   // storage
   always_ff @(posedge sys_clk)
   begin
      if (wr_go)
         mem[wr_ptr] <= wr.dat;
      if (rd_go)
         rd_dat_q <= mem[rd_ptr];  // lines up with rd ack
   end

   assign wr.ack = wr_ack_q;
   assign rd.ack = rd_ack_q;
   assign rd.dat = rd_dat_q;

endmodule

`default_nettype wire

// File: hw/erx_dispatch.sv
`default_nettype none

`include "erx_defines.svh"

module erx_dispatch (
   input  logic              sys_clk,
   input  logic              core_reset,
   erx_wb_if.master          rd,        // fifo read port
   output logic              wb_cyc,
   output logic              wb_stb,
   output logic              wb_we,
   output logic [`ERX_AW-1:0] wb_adr,
   output logic [`ERX_DW-1:0] wb_wdata,
   input  logic [`ERX_DW-1:0] wb_rdata,
   input  logic              wb_ack,
   output logic              rsp_valid, // one cycle per read
   output logic [`ERX_AW-1:0] rsp_addr,
   output logic [`ERX_DW-1:0] rsp_data
);
   import erx_pkg::*;

   logic        fetch;  // rd bus cycle open
   logic        busy;   // external cycle open
   erx_packet_t pkt;    // current packet

   //##############################
   // control
   //##############################
   // fetch -> busy -> fetch, never both
   always_ff @(posedge sys_clk or posedge core_reset)
   begin
      if (core_reset)
      begin
         fetch     <= 1'b0;
         busy      <= 1'b0;
         rsp_valid <= 1'b0;
      end
      else
      begin
         rsp_valid <= 1'b0;
         if (fetch)
         begin
            if (rd.ack)
            begin
               fetch <= 1'b0;
               busy  <= 1'b1;  // external cycle right after the fifo ack
            end
         end
         else if (busy)
         begin
            if (wb_ack)
            begin
               busy      <= 1'b0;
               fetch     <= 1'b1;
               rsp_valid <= ~pkt.write;
            end
         end
         else
            fetch <= 1'b1;  // first fetch out of reset
      end
   end

   //##############################
   // packet and response data
   //##############################
   always_ff @(posedge sys_clk)
   begin
      if (fetch && rd.ack)
         pkt <= rd.dat;
      if (busy && wb_ack && !pkt.write)
      begin
         rsp_addr <= pkt.payload.src_addr;  // return address of the read
         rsp_data <= wb_rdata;
      end
   end

   assign rd.cyc = fetch;
   assign rd.stb = fetch;
   assign rd.we  = 1'b0;  // pulling only

   assign wb_cyc   = busy;
   assign wb_stb   = busy;
   assign wb_we    = pkt.write;
   assign wb_adr   = pkt.dst_addr;
   assign wb_wdata = pkt.payload.wr_data;

endmodule

`default_nettype wire

// File: hw/erx_top.sv
`default_nettype none

`include "erx_defines.svh"

module erx_top (
   input  logic               sys_clk,
   input  logic               rx_reset,
   input  logic               soft_reset,
   input  logic               tx_active,
   input  logic               pll_locked,
   input  logic               idelay_ready,
   output logic               pll_reset,
   output logic               rx_active,
   input  logic               rx_frame,
   input  logic [7:0]         rx_data,
   output logic               rx_wait,
   output logic               wb_cyc,
   output logic               wb_stb,
   output logic               wb_we,
   output logic [`ERX_AW-1:0] wb_adr,
   output logic [`ERX_DW-1:0] wb_wdata,
   input  logic [`ERX_DW-1:0] wb_rdata,
   input  logic               wb_ack,
   output logic               rsp_valid,
   output logic [`ERX_AW-1:0] rsp_addr,
   output logic [`ERX_DW-1:0] rsp_data
);

   logic core_reset;  // for everything behind the sequencer

   erx_wb_if wr_bus ();  // assembler -> fifo
   erx_wb_if rd_bus ();  // fifo -> dispatcher

   //##############################
   // reset sequencing
   //##############################
   erx_reset_ctrl u_reset_ctrl (
      .sys_clk      (sys_clk),
      .rx_reset     (rx_reset),
      .soft_reset   (soft_reset),
      .tx_active    (tx_active),
      .pll_locked   (pll_locked),
      .idelay_ready (idelay_ready),
      .pll_reset    (pll_reset),
      .rx_active    (rx_active),
      .core_reset   (core_reset)
   );

   //##############################
   // receive path
   //##############################
   erx_protocol u_protocol (
      .sys_clk    (sys_clk),
      .core_reset (core_reset),
      .rx_frame   (rx_frame),
      .rx_data    (rx_data),
      .wr         (wr_bus.master)
   );

   erx_fifo u_fifo (
      .sys_clk    (sys_clk),
      .core_reset (core_reset),
      .wr         (wr_bus.slave),
      .rd         (rd_bus.slave),
      .rx_wait    (rx_wait)
   );

   erx_dispatch u_dispatch (
      .sys_clk    (sys_clk),
      .core_reset (core_reset),
      .rd         (rd_bus.master),
      .wb_cyc     (wb_cyc),
      .wb_stb     (wb_stb),
      .wb_we      (wb_we),
      .wb_adr     (wb_adr),
      .wb_wdata   (wb_wdata),
      .wb_rdata   (wb_rdata),
      .wb_ack     (wb_ack),
      .rsp_valid  (rsp_valid),
      .rsp_addr   (rsp_addr),
      .rsp_data   (rsp_data)
   );

endmodule

`default_nettype wire

// File: verif/erx_tb_clock.sv
`default_nettype none

// free running sys_clk for the testbench
module erx_tb_clock (
   output logic sys_clk
);

   localparam int HALF_PERIOD = 5;  // period 10

   initial
   begin
      sys_clk = 1'b0;
      forever
         #HALF_PERIOD sys_clk = ~sys_clk;
   end

endmodule

`default_nettype wire

// File: verif/erx_asserts.sv
`default_nettype none

`include "erx_defines.svh"

// bus and occupancy checks on the packet fifo
module erx_asserts (
   input logic                    sys_clk,
   input logic                    core_reset,
   input logic                    wr_stb,
   input logic                    wr_ack,
   input logic                    rd_stb,
   input logic                    rd_ack,
   input logic [`ERX_FIFO_CW-1:0] count
);

   int unsigned fail_cnt = 0;  // summed into the testbench error total

   //##############################
   // wishbone handshake
   //##############################
   // stb held until ack, both ports
   wr_stb_held: assert property (@(posedge sys_clk) disable iff (core_reset)
      wr_stb && !wr_ack |=> wr_stb)
   else
   begin
      fail_cnt++;
      $error("wr_bus stb dropped before ack");
   end

   rd_stb_held: assert property (@(posedge sys_clk) disable iff (core_reset)
      rd_stb && !rd_ack |=> rd_stb)
   else
   begin
      fail_cnt++;
      $error("rd_bus stb dropped before ack");
   end

   // no ack out of thin air
   wr_ack_stb: assert property (@(posedge sys_clk) disable iff (core_reset)
      wr_ack |-> wr_stb)
   else
   begin
      fail_cnt++;
      $error("wr_bus ack without stb");
   end

   rd_ack_stb: assert property (@(posedge sys_clk) disable iff (core_reset)
      rd_ack |-> rd_stb)
   else
   begin
      fail_cnt++;
      $error("rd_bus ack without stb");
   end

   //##############################
   // occupancy
   //##############################
   count_max: assert property (@(posedge sys_clk) disable iff (core_reset)
      count <= `ERX_FIFO_CW'(`ERX_FIFO_DEPTH))
   else
   begin
      fail_cnt++;
      $error("fifo count above depth");
   end

endmodule

bind erx_fifo erx_asserts u_asserts (
   .sys_clk    (sys_clk),
   .core_reset (core_reset),
   .wr_stb     (wr.stb),
   .wr_ack     (wr.ack),
   .rd_stb     (rd.stb),
   .rd_ack     (rd.ack),
   .count      (count)
);

`default_nettype wire

// File: verif/erx_tb.sv
`default_nettype none

`include "erx_defines.svh"

module erx_tb;
   import erx_pkg::*;

   localparam int          CLK_PERIOD = 10;
   localparam int          HB         = 1 << `ERX_RCW;  // cycles per heartbeat
   localparam int          N_PH1      = 48;             // before soft reset
   localparam int          N_PH2      = 16;             // after recovery
   localparam int          N_TOTAL    = N_PH1 + N_PH2;
   localparam int          GAP_MAX    = 3;
   localparam int          STALL_MAX  = 40 + 31;
   // abort frame + real frame + longest stall + fifo and dispatch overhead
   localparam int          PKT_WORST  = 9 + `ERX_FRAME_BYTES + GAP_MAX + STALL_MAX + 8;
   localparam int          SETUP_CYC  = 8 + 16 * HB;    // reset, start-up, soft reset
   localparam int          WATCHDOG_CYC = (N_TOTAL + 2) * PKT_WORST + SETUP_CYC;
   localparam logic [31:0] LFSR_SEED  = 32'h3f4c84c2;
   localparam logic [31:0] LFSR_TAPS  = 32'h8020_0003;  // x^32+x^22+x^2+x+1

   logic               sys_clk;
   logic               rx_reset;
   logic               soft_reset;
   logic               tx_active;
   logic               pll_locked;
   logic               idelay_ready;
   logic               pll_reset;
   logic               rx_active;
   logic               rx_frame;
   logic [7:0]         rx_data;
   logic               rx_wait;
   logic               wb_cyc;
   logic               wb_stb;
   logic               wb_we;
   logic [`ERX_AW-1:0] wb_adr;
   logic [`ERX_DW-1:0] wb_wdata;
   logic [`ERX_DW-1:0] wb_rdata;
   logic               wb_ack;
   logic               rsp_valid;
   logic [`ERX_AW-1:0] rsp_addr;
   logic [`ERX_DW-1:0] rsp_data;

   logic [31:0]        lfsr_state = LFSR_SEED;
   erx_packet_t        pkt_q [$];   // all packets, built up front
   int                 abort_q [$]; // bytes of a cut frame before each packet
   int                 gap_q [$];
   int                 stall_q [$];
   erx_packet_t        exp_q [$];   // sent, not yet on the external bus
   logic [63:0]        rsp_q [$];   // {src_addr, data} awaiting rsp_valid
   logic [31:0]        mem_model [logic [31:0]];
   int                 checks = 0;
   int                 value_errs = 0;
   int                 other_errs = 0;
   int                 writes_seen = 0;
   int                 reads_seen = 0;
   int                 rsp_seen = 0;
   logic               wait_seen = 1'b0;

   erx_tb_clock u_clock (
      .sys_clk (sys_clk)
   );

   erx_top dut (
      .sys_clk      (sys_clk),
      .rx_reset     (rx_reset),
      .soft_reset   (soft_reset),
      .tx_active    (tx_active),
      .pll_locked   (pll_locked),
      .idelay_ready (idelay_ready),
      .pll_reset    (pll_reset),
      .rx_active    (rx_active),
      .rx_frame     (rx_frame),
      .rx_data      (rx_data),
      .rx_wait      (rx_wait),
      .wb_cyc       (wb_cyc),
      .wb_stb       (wb_stb),
      .wb_we        (wb_we),
      .wb_adr       (wb_adr),
      .wb_wdata     (wb_wdata),
      .wb_rdata     (wb_rdata),
      .wb_ack       (wb_ack),
      .rsp_valid    (rsp_valid),
      .rsp_addr     (rsp_addr),
      .rsp_data     (rsp_data)
   );

   //##############################
   // helpers
   //##############################
   // galois step, one bit out per call
   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] v;
      v = '0;
      for (int i = 0; i < n; i++)
      begin
         v          = {v[30:0], lfsr_state[0]};
         lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ LFSR_TAPS) : (lfsr_state >> 1);
      end
      return v;
   endfunction

   // unwritten locations, whole address mixed in
   function automatic logic [31:0] fill_word(input logic [31:0] a);
      return {a[15:0], a[31:16]} ^ 32'h9e37_79b9;
   endfunction

   task automatic value_error(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
      value_errs++;
      $display("[ERROR] %s: got %h, expected %h", name, got, exp);
   endtask

   task automatic other_error(input string msg);
      other_errs++;
      $display("[ERROR] %s", msg);
   endtask

   task automatic next_cycle();
      @(posedge sys_clk);
      #1;  // drive and sample just past the edge
   endtask

   task automatic idle(input int n);
      rx_frame = 1'b0;
      repeat (n)
         next_cycle();
   endtask

   // ctrl, dst_addr, payload, msb first
   task automatic send_frame(input erx_packet_t p);
      logic [8*`ERX_FRAME_BYTES-1:0] fw;
      fw = {7'b0101101, p.write, p.dst_addr, p.payload};
      for (int i = `ERX_FRAME_BYTES - 1; i >= 0; i--)
      begin
         rx_frame = 1'b1;
         rx_data  = fw[8*i +: 8];
         next_cycle();
      end
   endtask

   task automatic send_junk(input int n);
      for (int i = 0; i < n; i++)
      begin
         rx_frame = 1'b1;
         rx_data  = 8'hc0 ^ 8'(i);
         next_cycle();
      end
   endtask

   task automatic build_stimulus();
      erx_packet_t p;
      for (int i = 0; i < N_TOTAL; i++)
      begin
         p.write = (rand_bits(1) != 0);
         if (rand_bits(2) != 0)
            p.dst_addr = 32'h4000_0000 | (rand_bits(4) << 2);  // small pool, reads hit
         else
            p.dst_addr = rand_bits(32);
         p.payload = rand_bits(32);  // data or return address
         pkt_q.push_back(p);
         abort_q.push_back((rand_bits(3) == 0) ? 1 + rand_bits(3) : 0);
         gap_q.push_back(rand_bits(2));
         stall_q.push_back((rand_bits(2) == 0) ? 40 + rand_bits(5) : rand_bits(2));
      end
   endtask

   task automatic run_traffic(input int first, input int last);
      for (int i = first; i < last; i++)
      begin
         if (abort_q[i] != 0)
         begin
            send_junk(abort_q[i]);  // cut short, must vanish
            idle(1);
         end
         while (rx_wait === 1'b1)  // hold off at the frame boundary
            next_cycle();
         send_frame(pkt_q[i]);
         exp_q.push_back(pkt_q[i]);
         idle(gap_q[i]);
      end
   endtask

   task automatic wait_rx_active(input logic level, input int limit, output logic ok);
      int n;
      n = 0;
      while (rx_active !== level && n < limit)
      begin
         next_cycle();
         n++;
      end
      ok = (rx_active === level);
   endtask

   task automatic wait_drain(input int limit);
      int n;
      n = 0;
      while ((exp_q.size() != 0 || rsp_q.size() != 0 || wb_cyc === 1'b1) && n < limit)
      begin
         next_cycle();
         n++;
      end
      if (exp_q.size() != 0 || rsp_q.size() != 0)
         other_error("traffic did not drain in time");
      repeat (4)
         next_cycle();
   endtask

   //##############################
   // external memory model
   //##############################
   initial
   begin : bus_responder
      erx_packet_t exp;
      logic        have_exp;
      int          stall;
      wb_ack   = 1'b0;
      wb_rdata = '0;
      forever
      begin
         next_cycle();
         if (wb_cyc === 1'b1 && wb_stb === 1'b1)
         begin
            stall    = (stall_q.size() != 0) ? stall_q.pop_front() : 0;
            have_exp = (exp_q.size() != 0);
            if (!have_exp)
               other_error("external bus cycle with no packet outstanding");
            else
            begin
               exp = exp_q.pop_front();
               checks++;
               if (wb_we !== exp.write)
                  value_error("wb_we", {31'b0, wb_we}, {31'b0, exp.write});
               if (wb_adr !== exp.dst_addr)
                  value_error("wb_adr", wb_adr, exp.dst_addr);
               if (exp.write && wb_wdata !== exp.payload.wr_data)
                  value_error("wb_wdata", wb_wdata, exp.payload.wr_data);
            end
            repeat (stall)
            begin
               next_cycle();
               if (wb_cyc !== 1'b1)
                  other_error("wb_cyc dropped before wb_ack");
            end
            if (have_exp && exp.write)
            begin
               writes_seen++;
               mem_model[exp.dst_addr] = exp.payload.wr_data;
            end
            else if (have_exp)
            begin
               reads_seen++;
               wb_rdata = mem_model.exists(exp.dst_addr) ? mem_model[exp.dst_addr]
                                                         : fill_word(exp.dst_addr);
               rsp_q.push_back({exp.payload.src_addr, wb_rdata});
            end
            wb_ack = 1'b1;
            next_cycle();
            wb_ack = 1'b0;  // master drops cyc on this edge
         end
      end
   end

   // read responses, in order
   initial
   begin : rsp_monitor
      logic [63:0] exp_r;
      forever
      begin
         next_cycle();
         if (rsp_valid === 1'b1)
         begin
            rsp_seen++;
            if (rsp_q.size() == 0)
               other_error("rsp_valid with no read outstanding");
            else
            begin
               exp_r = rsp_q.pop_front();
               checks++;
               if (rsp_addr !== exp_r[63:32])
                  value_error("rsp_addr", rsp_addr, exp_r[63:32]);
               if (rsp_data !== exp_r[31:0])
                  value_error("rsp_data", rsp_data, exp_r[31:0]);
            end
         end
      end
   end

   initial
   begin : wait_watch
      forever
      begin
         next_cycle();
         if (rx_wait === 1'b1)
            wait_seen = 1'b1;
      end
   end

   initial
   begin : watchdog
      #(WATCHDOG_CYC * CLK_PERIOD);
      $display("watchdog expired after %0d cycles, run stopped", WATCHDOG_CYC);
      $display("Done: errors found");
      $finish;
   end

   //##############################
   // main sequence
   //##############################
   initial
   begin : main_seq
      erx_packet_t junk;
      logic        ok;
      int          errs;
      rx_reset     = 1'b1;
      soft_reset   = 1'b0;
      tx_active    = 1'b1;
      pll_locked   = 1'b0;
      idelay_ready = 1'b0;
      rx_frame     = 1'b0;
      rx_data      = 8'h00;
      junk         = {1'b1, 32'h7000_0010, 32'h1234_5678};
      build_stimulus();
      repeat (8)
         @(posedge sys_clk);
      #1;
      rx_reset = 1'b0;

      // start-up, pll not locked yet
      checks++;
      if (pll_reset !== 1'b1)
         value_error("pll_reset", {31'b0, pll_reset}, 32'h1);
      if (rx_active !== 1'b0)
         value_error("rx_active", {31'b0, rx_active}, 32'h0);
      repeat (4 * HB)
      begin
         next_cycle();
         if (rx_active === 1'b1)
         begin
            other_error("rx_active rose before pll lock");
            break;
         end
      end
      pll_locked   = 1'b1;
      idelay_ready = 1'b1;
      wait_rx_active(1'b1, 3 * HB, ok);
      checks++;
      if (!ok)
         other_error("rx_active not up within 3 heartbeats of lock");
      if (pll_reset !== 1'b0)
         value_error("pll_reset", {31'b0, pll_reset}, 32'h0);
      repeat (4)
         next_cycle();  // core reset lets go 2 cycles after rx_active

      // writes, reads, aborts, back-pressure
      run_traffic(0, N_PH1);
      wait_drain(N_PH1 * PKT_WORST);

      // soft reset, link must go quiet
      soft_reset = 1'b1;
      wait_rx_active(1'b0, HB + 1, ok);
      checks++;
      if (!ok)
         other_error("rx_active still high a heartbeat after soft_reset");
      if (pll_reset !== 1'b1)
         value_error("pll_reset", {31'b0, pll_reset}, 32'h1);
      send_frame(junk);  // dropped, core held in reset
      idle(2);
      send_frame(junk);
      idle(1);
      repeat (3 * HB)
      begin
         next_cycle();
         if (rx_active === 1'b1 || wb_cyc === 1'b1)
         begin
            other_error("link active or bus cycle while soft_reset held");
            break;
         end
      end
      soft_reset = 1'b0;
      wait_rx_active(1'b1, 3 * HB, ok);
      if (!ok)
         other_error("link did not recover after soft_reset release");
      repeat (4)
         next_cycle();
      run_traffic(N_PH1, N_TOTAL);
      wait_drain(N_PH2 * PKT_WORST);

      // end of run
      if (!wait_seen)
         other_error("rx_wait never rose under long wb_ack stalls");
      if (rsp_seen != reads_seen)
         other_error("number of rsp_valid pulses differs from reads");
      if (writes_seen + reads_seen != N_TOTAL)
         other_error("number of external bus cycles differs from packets sent");
      errs = value_errs + other_errs + int'(dut.u_fifo.u_asserts.fail_cnt);
      $display("checks %0d, writes %0d, reads %0d, value errors %0d, other errors %0d, %s %0d",
               checks, writes_seen, reads_seen, value_errs, other_errs,
               "assertion failures", dut.u_fifo.u_asserts.fail_cnt);
      if (errs == 0)
         $display("Done: no errors");
      else
         $display("Done: errors found");
      $finish;
   end

endmodule

`default_nettype wire

// File: files.f
+incdir+hw
hw/erx_pkg.sv
hw/erx_wb_if.sv
hw/erx_reset_ctrl.sv
hw/erx_protocol.sv
hw/erx_fifo.sv
hw/erx_dispatch.sv
hw/erx_top.sv
verif/erx_tb_clock.sv
verif/erx_asserts.sv
verif/erx_tb.sv

// File: run_sim.sh
#!/bin/sh
# build the receiver testbench with verilator, run it, judge by the log
rm -f sim.log
verilator --binary --timing --assert -f files.f --top-module erx_tb -o erx_sim \
   && ./obj_dir/erx_sim | tee sim.log
grep -q "^Done: no errors$" sim.log \
   && echo "simulation passed" \
   || { echo "simulation failed"; exit 1; }
